// ==== logic/bus_pkg.sv ====
package bus_pkg;

    // Bus address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // One write enable per data byte
    typedef logic [3:0] strb_t;

    // Region index, the top nibble of the address
    typedef logic [3:0] region_t;

    // DDS frequency word and phase accumulator
    typedef logic [31:0] phase_t;

    // One wave sample per channel
    typedef logic [7:0] sample_t;

    // Address map
    localparam region_t MEM_REGION = 4'h0;
    localparam region_t DDS_REGION = 4'h2;

    // Read data that goes out with an error response
    localparam data_t BUS_ERR_DATA = 32'hDEAD_BEEF;

    // Bytes per word
    localparam int WORD_BYTES = 4;

    // First address bit above the byte offset
    localparam int WORD_LSB = $clog2(WORD_BYTES);

    // First address bit of the region nibble
    localparam int REGION_LSB = $bits(addr_t) - $bits(region_t);

endpackage

// ==== logic/bus_req_if.sv ====
`timescale 1ns/1ps

interface bus_req_if (
    input logic clk
);
    import bus_pkg::*;

    // Request side, one-cycle strobe
    logic  req;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t strb;

    // Response side, one-cycle strobe
    logic  rsp_valid;
    data_t rdata;
    logic  err;

    // Issues requests and takes responses
    modport master (
        input  clk,
        output req, write, addr, wdata, strb,
        input  rsp_valid, rdata, err
    );

    // Takes requests and returns responses
    modport slave (
        input  clk,
        input  req, write, addr, wdata, strb,
        output rsp_valid, rdata, err
    );

endinterface

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input logic      clk,
    input logic      rst_n,
    bus_req_if.slave m0_bus,
    bus_req_if.slave m1_bus,
    bus_req_if.master arb_bus
);
    import bus_pkg::*;

    localparam int MASTER_NUM = 2;

    // Live requests from both masters, index is the master number
    logic  [MASTER_NUM-1:0] in_req;
    logic  [MASTER_NUM-1:0] in_write;
    addr_t [MASTER_NUM-1:0] in_addr;
    data_t [MASTER_NUM-1:0] in_wdata;
    strb_t [MASTER_NUM-1:0] in_strb;

    // One-deep slot for a request that lost a tie
    logic  [MASTER_NUM-1:0] pend_valid;
    logic  [MASTER_NUM-1:0] pend_write;
    addr_t [MASTER_NUM-1:0] pend_addr;
    data_t [MASTER_NUM-1:0] pend_wdata;
    strb_t [MASTER_NUM-1:0] pend_strb;

    // Candidates, the pending slot takes priority over the live port
    logic  [MASTER_NUM-1:0] cand_valid;
    logic  [MASTER_NUM-1:0] cand_write;
    addr_t [MASTER_NUM-1:0] cand_addr;
    data_t [MASTER_NUM-1:0] cand_wdata;
    strb_t [MASTER_NUM-1:0] cand_strb;

    logic gnt;
    logic last_win;
    logic tag_q;
    logic rsp_tag;

    assign in_req   = {m1_bus.req,   m0_bus.req};
    assign in_write = {m1_bus.write, m0_bus.write};
    assign in_addr  = {m1_bus.addr,  m0_bus.addr};
    assign in_wdata = {m1_bus.wdata, m0_bus.wdata};
    assign in_strb  = {m1_bus.strb,  m0_bus.strb};

    always_comb begin
        for (int m = 0; m < MASTER_NUM; m++) begin
            cand_valid[m] = pend_valid[m] | in_req[m];
            cand_write[m] = pend_valid[m] ? pend_write[m] : in_write[m];
            cand_addr[m]  = pend_valid[m] ? pend_addr[m]  : in_addr[m];
            cand_wdata[m] = pend_valid[m] ? pend_wdata[m] : in_wdata[m];
            cand_strb[m]  = pend_valid[m] ? pend_strb[m]  : in_strb[m];
        end
    end

    // Round robin on a tie, otherwise whoever asks
    always_comb begin
        if (&cand_valid) begin
            gnt = ~last_win;
        end else begin
            gnt = cand_valid[1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arb_bus.req <= 1'b0;
            pend_valid  <= '0;
            last_win    <= 1'b1;
            tag_q       <= 1'b0;
            rsp_tag     <= 1'b0;
        end else begin
            arb_bus.req <= |cand_valid;
            // Pointer moves only on contention, so repeated ties alternate
            if (&cand_valid) begin
                last_win <= gnt;
            end
            // Loser waits one cycle in its slot
            for (int m = 0; m < MASTER_NUM; m++) begin
                pend_valid[m] <= cand_valid[m] && (int'(gnt) != m);
            end
            // Tag follows the request, then the fixed one-cycle slave latency
            tag_q   <= gnt;
            rsp_tag <= tag_q;
        end
    end

    // Request payload and pending payload
    always_ff @(posedge clk) begin
        arb_bus.write <= cand_write[gnt];
        arb_bus.addr  <= cand_addr[gnt];
        arb_bus.wdata <= cand_wdata[gnt];
        arb_bus.strb  <= cand_strb[gnt];
        for (int m = 0; m < MASTER_NUM; m++) begin
            if (cand_valid[m] && (int'(gnt) != m)) begin
                pend_write[m] <= cand_write[m];
                pend_addr[m]  <= cand_addr[m];
                pend_wdata[m] <= cand_wdata[m];
                pend_strb[m]  <= cand_strb[m];
            end
        end
    end

    // Response goes back to its owner
    assign m0_bus.rsp_valid = arb_bus.rsp_valid & ~rsp_tag;
    assign m1_bus.rsp_valid = arb_bus.rsp_valid & rsp_tag;
    assign m0_bus.err       = arb_bus.err & ~rsp_tag;
    assign m1_bus.err       = arb_bus.err & rsp_tag;
    assign m0_bus.rdata     = arb_bus.rdata;
    assign m1_bus.rdata     = arb_bus.rdata;

endmodule

// ==== logic/region_decoder.sv ====
`timescale 1ns/1ps

module region_decoder (
    input logic       clk,
    input logic       rst_n,
    bus_req_if.slave  arb_bus,
    bus_req_if.master mem_bus,
    bus_req_if.master dds_bus
);
    import bus_pkg::*;

    // Where the current request goes
    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_MEM,
        TGT_DDS,
        TGT_ERR
    } target_e;

    region_t region;
    target_e target;
    target_e target_q;

    assign region = arb_bus.addr[REGION_LSB +: $bits(region_t)];

    always_comb begin
        if (!arb_bus.req) begin
            target = TGT_NONE;
        end else if (region == MEM_REGION) begin
            target = TGT_MEM;
        end else if (region == DDS_REGION) begin
            target = TGT_DDS;
        end else begin
            target = TGT_ERR;
        end
    end

    // Strobe only to the selected slave
    assign mem_bus.req = (target == TGT_MEM);
    assign dds_bus.req = (target == TGT_DDS);

    // Payload shared by both slaves
    assign mem_bus.write = arb_bus.write;
    assign mem_bus.addr  = arb_bus.addr;
    assign mem_bus.wdata = arb_bus.wdata;
    assign mem_bus.strb  = arb_bus.strb;
    assign dds_bus.write = arb_bus.write;
    assign dds_bus.addr  = arb_bus.addr;
    assign dds_bus.wdata = arb_bus.wdata;
    assign dds_bus.strb  = arb_bus.strb;

    // Target of last cycle lines up with the slave response
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            target_q <= TGT_NONE;
        end else begin
            target_q <= target;
        end
    end

    always_comb begin
        case (target_q)
            TGT_MEM: begin
                arb_bus.rsp_valid = mem_bus.rsp_valid;
                arb_bus.rdata     = mem_bus.rdata;
                arb_bus.err       = mem_bus.err;
            end
            TGT_DDS: begin
                arb_bus.rsp_valid = dds_bus.rsp_valid;
                arb_bus.rdata     = dds_bus.rdata;
                arb_bus.err       = dds_bus.err;
            end
            // Unmapped region, no slave was touched
            TGT_ERR: begin
                arb_bus.rsp_valid = 1'b1;
                arb_bus.rdata     = BUS_ERR_DATA;
                arb_bus.err       = 1'b1;
            end
            default: begin
                arb_bus.rsp_valid = 1'b0;
                arb_bus.rdata     = '0;
                arb_bus.err       = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/mem_slave.sv ====
`timescale 1ns/1ps

module mem_slave #(
    parameter int MEM_WORDS = 256
) (
    input logic      clk,
    input logic      rst_n,
    bus_req_if.slave bus
);
    import bus_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    // Word storage for the DDR region
    data_t mem [MEM_WORDS];

    // Word index, higher offset bits are dropped so the region wraps
    logic [IDX_W-1:0] idx;

    assign idx = bus.addr[WORD_LSB +: IDX_W];

    // Response strobe one cycle after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.rsp_valid <= 1'b0;
        end else begin
            bus.rsp_valid <= bus.req;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req) begin
            if (bus.write) begin
                // Merge only the enabled bytes
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (bus.strb[b]) begin
                        mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
                bus.rdata <= '0;
            end else begin
                bus.rdata <= mem[idx];
            end
        end
    end

    // Every offset in the region is valid
    assign bus.err = 1'b0;

endmodule

// ==== logic/dds_slave.sv ====
`timescale 1ns/1ps

module dds_slave #(
    parameter int CHANNEL_NUM = 2
) (
    input  logic                              clk,
    input  logic                              rst_n,
    bus_req_if.slave                          bus,
    output bus_pkg::sample_t [CHANNEL_NUM-1:0] wave_out
);
    import bus_pkg::*;

    // Frequency word and phase per channel
    phase_t [CHANNEL_NUM-1:0] freq;
    phase_t [CHANNEL_NUM-1:0] phase;

    // Word offset inside the region
    addr_t word_off;
    data_t rd_word;

    assign word_off = addr_t'(bus.addr[REGION_LSB-1:WORD_LSB]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            freq  <= '0;
            phase <= '0;
        end else begin
            for (int k = 0; k < CHANNEL_NUM; k++) begin
                // Accumulator runs every cycle
                phase[k] <= phase[k] + freq[k];
                // Byte-strobed write of the frequency word
                if (bus.req && bus.write && (word_off == addr_t'(k))) begin
                    for (int b = 0; b < WORD_BYTES; b++) begin
                        if (bus.strb[b]) begin
                            freq[k][8*b +: 8] <= bus.wdata[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // Readback, offsets past the last channel read zero
    always_comb begin
        rd_word = '0;
        for (int k = 0; k < CHANNEL_NUM; k++) begin
            if (word_off == addr_t'(k)) begin
                rd_word = freq[k];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.rsp_valid <= 1'b0;
        end else begin
            bus.rsp_valid <= bus.req;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req) begin
            bus.rdata <= bus.write ? '0 : rd_word;
        end
    end

    assign bus.err = 1'b0;

    // Sample is the top byte of the phase
    always_comb begin
        for (int k = 0; k < CHANNEL_NUM; k++) begin
            wave_out[k] = phase[k][$bits(phase_t)-1 -: $bits(sample_t)];
        end
    end

endmodule

// ==== logic/bus_system_top.sv ====
`timescale 1ns/1ps

module bus_system_top #(
    parameter int MEM_WORDS   = 256,
    parameter int CHANNEL_NUM = 2
) (
    input  logic                               bus_clk,
    input  logic                               rst_n,
    // Master 0
    input  logic                               m0_req,
    input  logic                               m0_write,
    input  bus_pkg::addr_t                     m0_addr,
    input  bus_pkg::data_t                     m0_wdata,
    input  bus_pkg::strb_t                     m0_strb,
    output logic                               m0_rsp_valid,
    output bus_pkg::data_t                     m0_rdata,
    output logic                               m0_err,
    // Master 1
    input  logic                               m1_req,
    input  logic                               m1_write,
    input  bus_pkg::addr_t                     m1_addr,
    input  bus_pkg::data_t                     m1_wdata,
    input  bus_pkg::strb_t                     m1_strb,
    output logic                               m1_rsp_valid,
    output bus_pkg::data_t                     m1_rdata,
    output logic                               m1_err,
    // DDS samples
    output bus_pkg::sample_t [CHANNEL_NUM-1:0] wave_out
);

    bus_req_if m0_bus  (.clk(bus_clk));
    bus_req_if m1_bus  (.clk(bus_clk));
    bus_req_if arb_bus (.clk(bus_clk));
    bus_req_if mem_bus (.clk(bus_clk));
    bus_req_if dds_bus (.clk(bus_clk));

    // Master ports onto their buses
    assign m0_bus.req   = m0_req;
    assign m0_bus.write = m0_write;
    assign m0_bus.addr  = m0_addr;
    assign m0_bus.wdata = m0_wdata;
    assign m0_bus.strb  = m0_strb;
    assign m0_rsp_valid = m0_bus.rsp_valid;
    assign m0_rdata     = m0_bus.rdata;
    assign m0_err       = m0_bus.err;

    assign m1_bus.req   = m1_req;
    assign m1_bus.write = m1_write;
    assign m1_bus.addr  = m1_addr;
    assign m1_bus.wdata = m1_wdata;
    assign m1_bus.strb  = m1_strb;
    assign m1_rsp_valid = m1_bus.rsp_valid;
    assign m1_rdata     = m1_bus.rdata;
    assign m1_err       = m1_bus.err;

    bus_arbiter u_bus_arbiter (
        .clk     (bus_clk),
        .rst_n   (rst_n),
        .m0_bus  (m0_bus),
        .m1_bus  (m1_bus),
        .arb_bus (arb_bus)
    );

    region_decoder u_region_decoder (
        .clk     (bus_clk),
        .rst_n   (rst_n),
        .arb_bus (arb_bus),
        .mem_bus (mem_bus),
        .dds_bus (dds_bus)
    );

    mem_slave #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem_slave (
        .clk   (bus_clk),
        .rst_n (rst_n),
        .bus   (mem_bus)
    );

    dds_slave #(
        .CHANNEL_NUM (CHANNEL_NUM)
    ) u_dds_slave (
        .clk      (bus_clk),
        .rst_n    (rst_n),
        .bus      (dds_bus),
        .wave_out (wave_out)
    );

endmodule

// ==== tests/bus_system_tb.sv ====
`timescale 1ns/1ps

module bus_system_tb;
    import bus_pkg::*;

    localparam int MEM_WORDS   = 256;
    localparam int CHANNEL_NUM = 2;
    localparam int SEED        = 40998;
    localparam int RAND_TXN    = 200;
    // Directed, prefill and random transactions
    localparam int TXN_NUM     = 3 + 16 + 3 + 2 + 16 + RAND_TXN;
    localparam int CYCLE_LIMIT = TXN_NUM * 3 + 200;

    // Expected response and the cycle it must show up in
    typedef struct packed {
        data_t data;
        logic  err;
        int    due;
    } exp_t;

    logic bus_clk = 1'b0;
    logic rst_n;
    logic m0_req, m0_write, m0_rsp_valid, m0_err;
    logic m1_req, m1_write, m1_rsp_valid, m1_err;
    addr_t m0_addr, m1_addr;
    data_t m0_wdata, m1_wdata, m0_rdata, m1_rdata;
    strb_t m0_strb, m1_strb;
    sample_t [CHANNEL_NUM-1:0] wave_out;

    // Shadow state of the reference model
    data_t  shadow_mem  [MEM_WORDS];
    phase_t shadow_freq [CHANNEL_NUM];
    exp_t   exp_q0 [$];
    exp_t   exp_q1 [$];

    logic [1:0] busy = 2'b00;
    // Master that wins the next tie
    int tie_next    = 0;
    int cycle       = 0;
    int checks      = 0;
    int errors      = 0;
    int base_checks = 0;
    int base_errors = 0;

    bus_system_top #(
        .MEM_WORDS   (MEM_WORDS),
        .CHANNEL_NUM (CHANNEL_NUM)
    ) u_bus_system_top (
        .bus_clk      (bus_clk),
        .rst_n        (rst_n),
        .m0_req       (m0_req),
        .m0_write     (m0_write),
        .m0_addr      (m0_addr),
        .m0_wdata     (m0_wdata),
        .m0_strb      (m0_strb),
        .m0_rsp_valid (m0_rsp_valid),
        .m0_rdata     (m0_rdata),
        .m0_err       (m0_err),
        .m1_req       (m1_req),
        .m1_write     (m1_write),
        .m1_addr      (m1_addr),
        .m1_wdata     (m1_wdata),
        .m1_strb      (m1_strb),
        .m1_rsp_valid (m1_rsp_valid),
        .m1_rdata     (m1_rdata),
        .m1_err       (m1_err),
        .wave_out     (wave_out)
    );

    always #2 bus_clk = ~bus_clk;

    // Run length guard
    always @(posedge bus_clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic data_t merge(input data_t old, input data_t wdata, input strb_t strb);
        data_t res;
        res = old;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Prefill data mixed from the full address
    function automatic data_t fill_word(input addr_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'hA5C3_0F96;
    endfunction

    // Expected response from the address map with shadow state updates
    function automatic exp_t ref_access(input logic write, input addr_t addr,
                                        input data_t wdata, input strb_t strb);
        exp_t    e;
        int      idx;
        region_t region;
        region = addr[31:28];
        e.data = '0;
        e.err  = 1'b0;
        e.due  = 0;
        if (region == MEM_REGION) begin
            // Offsets past the memory depth wrap
            idx = int'((addr / WORD_BYTES) % MEM_WORDS);
            if (write) begin
                shadow_mem[idx] = merge(shadow_mem[idx], wdata, strb);
            end else begin
                e.data = shadow_mem[idx];
            end
        end else if (region == DDS_REGION) begin
            idx = int'((addr & 32'h0FFF_FFFF) / WORD_BYTES);
            if (idx < CHANNEL_NUM) begin
                if (write) begin
                    shadow_freq[idx] = merge(shadow_freq[idx], wdata, strb);
                end else begin
                    e.data = shadow_freq[idx];
                end
            end
        end else begin
            e.data = BUS_ERR_DATA;
            e.err  = 1'b1;
        end
        return e;
    endfunction

    // On each falling edge request strobes drop and finished masters go idle
    task automatic step();
        @(negedge bus_clk);
        m0_req = 1'b0;
        m1_req = 1'b0;
        if (m0_rsp_valid) begin
            busy[0] = 1'b0;
        end
        if (m1_rsp_valid) begin
            busy[1] = 1'b0;
        end
    endtask

    task automatic wait_idle();
        while (busy != 2'b00) begin
            step();
        end
    endtask

    // Drive one request at the current falling edge
    task automatic issue(input int m, input logic write, input addr_t addr,
                         input data_t wdata, input strb_t strb, input int lat);
        exp_t e;
        e     = ref_access(write, addr, wdata, strb);
        e.due = cycle + lat;
        if (m == 0) begin
            m0_req   = 1'b1;
            m0_write = write;
            m0_addr  = addr;
            m0_wdata = wdata;
            m0_strb  = strb;
            exp_q0.push_back(e);
        end else begin
            m1_req   = 1'b1;
            m1_write = write;
            m1_addr  = addr;
            m1_wdata = wdata;
            m1_strb  = strb;
            exp_q1.push_back(e);
        end
        busy[m] = 1'b1;
    endtask

    // Tie with the winner served first and the loser one cycle later
    task automatic issue_both(input logic w0, input addr_t a0, input data_t d0, input strb_t s0,
                              input logic w1, input addr_t a1, input data_t d1, input strb_t s1);
        if (tie_next == 0) begin
            issue(0, w0, a0, d0, s0, 2);
            issue(1, w1, a1, d1, s1, 3);
            tie_next = 1;
        end else begin
            issue(1, w1, a1, d1, s1, 2);
            issue(0, w0, a0, d0, s0, 3);
            tie_next = 0;
        end
    endtask

    task automatic rand_txn(output logic write, output addr_t addr,
                            output data_t wdata, output strb_t strb);
        int          sel;
        logic [17:0] high;
        logic [3:0]  word;
        logic [1:0]  off;
        logic [27:0] low;
        region_t     nib;
        sel   = $urandom_range(0, 4);
        write = 1'($urandom_range(0, 1));
        wdata = $urandom;
        strb  = 4'($urandom_range(0, 15));
        high  = 18'($urandom);
        word  = 4'($urandom);
        off   = 2'($urandom_range(0, 3));
        low   = 28'($urandom);
        nib   = (sel == 4) ? 4'h1 : 4'($urandom_range(3, 15));
        if (sel < 2) begin
            // Prefilled words with random upper offset bits to exercise the wrap
            addr = {MEM_REGION, high, 4'h0, word, 2'b00};
        end else if (sel == 2) begin
            // Two frequency words and two empty offsets
            addr = {DDS_REGION, 24'h0, off, 2'b00};
        end else begin
            addr = {nib, low};
        end
    endtask

    task automatic check_rsp(input int m, input data_t rdata, input logic err);
        exp_t e;
        int   left;
        left = (m == 0) ? exp_q0.size() : exp_q1.size();
        checks++;
        assert (left > 0) else begin
            errors++;
            $display("Master %0d got a response with no request outstanding", m);
        end
        if (left > 0) begin
            e = (m == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
            assert (rdata === e.data && err === e.err && cycle == e.due) else begin
                errors++;
                $display("Fail at %0t: m%0d got %h %b cycle %0d, expected %h %b cycle %0d",
                         $time, m, rdata, err, cycle, e.data, e.err, e.due);
            end
        end
    endtask

    task automatic report(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - base_checks, errors - base_errors);
        base_checks = checks;
        base_errors = errors;
    endtask

    // Responses compared at the falling edge where outputs are stable
    always @(negedge bus_clk) begin
        if (rst_n) begin
            if (m0_rsp_valid) begin
                check_rsp(0, m0_rdata, m0_err);
            end
            if (m1_rsp_valid) begin
                check_rsp(1, m1_rdata, m1_err);
            end
        end
    end

    initial begin
        logic    w0, w1, want0, want1;
        addr_t   a0, a1;
        data_t   d0, d1;
        strb_t   s0, s1;
        sample_t prev0, prev1;
        int      remaining;
        int      seed_ret;
        seed_ret = $urandom(SEED);
        rst_n    = 1'b0;
        m0_req   = 1'b0;
        m0_write = 1'b0;
        m0_addr  = '0;
        m0_wdata = '0;
        m0_strb  = '0;
        m1_req   = 1'b0;
        m1_write = 1'b0;
        m1_addr  = '0;
        m1_wdata = '0;
        m1_strb  = '0;
        for (int k = 0; k < CHANNEL_NUM; k++) begin
            shadow_freq[k] = '0;
        end

        // Outputs quiet during reset and one cycle after
        for (int i = 0; i < 17; i++) begin
            @(negedge bus_clk);
            if (i == 15) begin
                rst_n = 1'b1;
            end
            checks++;
            assert (!m0_rsp_valid && !m1_rsp_valid && wave_out == '0) else begin
                errors++;
                $display("Fail at %0t: outputs active around reset", $time);
            end
        end
        step();
        report("Reset");

        // Full write, partial write, read back of the merged word
        issue(0, 1'b1, 32'h0000_0010, 32'h1122_3344, 4'hF, 2);
        wait_idle();
        issue(0, 1'b1, 32'h0000_0010, 32'hAABB_CCDD, 4'b0101, 2);
        wait_idle();
        issue(0, 1'b0, 32'h0000_0010, '0, '0, 2);
        wait_idle();
        report("Memory write and read");

        // Repeated ties where the winner has to alternate
        for (int i = 0; i < 4; i++) begin
            issue_both(1'b1, 32'h0000_0100 + 4 * i, 32'h1000_0000 + i, 4'hF,
                       1'b1, 32'h0000_0200 + 4 * i, 32'h2000_0000 + i, 4'hF);
            wait_idle();
            issue_both(1'b0, 32'h0000_0100 + 4 * i, '0, '0,
                       1'b0, 32'h0000_0200 + 4 * i, '0, '0);
            wait_idle();
        end
        report("Simultaneous requests");

        // Unmapped regions leave the memory word at the same offset alone
        issue(1, 1'b1, 32'h1000_0010, 32'h5555_AAAA, 4'hF, 2);
        wait_idle();
        issue(0, 1'b0, 32'hF000_0010, '0, '0, 2);
        wait_idle();
        issue(1, 1'b0, 32'h0000_0010, '0, '0, 2);
        wait_idle();
        report("Unmapped region");

        // Channel 0 steps its top byte once per cycle
        issue(0, 1'b1, 32'h2000_0000, 32'h0100_0000, 4'hF, 2);
        wait_idle();
        issue(0, 1'b0, 32'h2000_0000, '0, '0, 2);
        wait_idle();
        prev0 = wave_out[0];
        prev1 = wave_out[1];
        for (int i = 0; i < 8; i++) begin
            step();
            checks++;
            assert (wave_out[0] == sample_t'(prev0 + 8'd1) && wave_out[1] == prev1) else begin
                errors++;
                $display("Fail at %0t: wave_out %h %h after %h %h",
                         $time, wave_out[0], wave_out[1], prev0, prev1);
            end
            prev0 = wave_out[0];
        end
        report("DDS");

        // Known contents for the random window
        for (int i = 0; i < 16; i++) begin
            issue(0, 1'b1, 32'(4 * i), fill_word(32'(4 * i)), 4'hF, 2);
            wait_idle();
        end
        report("Memory prefill");

        remaining = RAND_TXN;
        while (remaining > 0) begin
            step();
            want0 = !busy[0] && ($urandom_range(0, 3) != 0);
            want1 = !busy[1] && ($urandom_range(0, 3) != 0) && (remaining > 1 || !want0);
            if (want0) begin
                rand_txn(w0, a0, d0, s0);
            end
            if (want1) begin
                rand_txn(w1, a1, d1, s1);
            end
            if (want0 && want1) begin
                issue_both(w0, a0, d0, s0, w1, a1, d1, s1);
                remaining -= 2;
            end else if (want0) begin
                issue(0, w0, a0, d0, s0, 2);
                remaining--;
            end else if (want1) begin
                issue(1, w1, a1, d1, s1, 2);
                remaining--;
            end
        end
        wait_idle();
        step();
        report("Random traffic");

        // Every expected response has been consumed
        checks++;
        assert (exp_q0.size() == 0 && exp_q1.size() == 0) else begin
            errors++;
            $display("Responses never arrived: %0d for master 0 and %0d for master 1",
                     exp_q0.size(), exp_q1.size());
        end

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== src.f ====
logic/bus_pkg.sv
logic/bus_req_if.sv
logic/bus_arbiter.sv
logic/region_decoder.sv
logic/mem_slave.sv
logic/dds_slave.sv
logic/bus_system_top.sv
tests/bus_system_tb.sv

// ==== Bender.yml ====
package:
  name: bus_system

sources:
  - logic/bus_pkg.sv
  - logic/bus_req_if.sv
  - logic/bus_arbiter.sv
  - logic/region_decoder.sv
  - logic/mem_slave.sv
  - logic/dds_slave.sv
  - logic/bus_system_top.sv
  - target: test
    files:
      - tests/bus_system_tb.sv
